/* common/fetch_pkg.sv */
// Fetch constants: reset address, PC step, ROM depth and program image path
`default_nettype none

package fetch_pkg;

   // First fetch address out of reset
   localparam logic [15:0] RESET_PC = 16'h0000;

   // Byte addressed PC, two bytes per instruction
   localparam logic [15:0] PC_STEP = 16'd2;

   // ROM depth in words
   localparam int ROM_WORDS = 32;

   // Word index width into the ROM
   localparam int ROM_AW = $clog2(ROM_WORDS);

   // Program image, one hex word per line
   localparam string ROM_FILE = "verif/program.hex";

endpackage

`default_nettype wire

/* common/isa_pkg.sv */
// ISA widths, opcode encoding, instruction formats and the instruction word union
`default_nettype none

package isa_pkg;

   // Word and field widths
   localparam int WORD_W = 16;
   localparam int REG_W  = 4;
   localparam int OPC_W  = 4;
   localparam int IMM_W  = 4;
   localparam int OFS_W  = 12;

   // Opcode field, top nibble of every word
   typedef enum logic [OPC_W-1:0] {
      OP_NOP   = 4'd0,
      OP_ADD   = 4'd1,
      OP_SUB   = 4'd2,
      OP_AND   = 4'd3,
      OP_ADDI  = 4'd4,
      OP_LOAD  = 4'd5,
      OP_STORE = 4'd6,
      OP_BR    = 4'd7
   } opcode_e;

   // All-zero word decodes as NOP, used for bubbles
   localparam logic [WORD_W-1:0] NOP_WORD = '0;

   // Register format: ADD, SUB, AND
   typedef struct packed {
      opcode_e          opcode;
      logic [REG_W-1:0] rd;
      logic [REG_W-1:0] rs;
      logic [REG_W-1:0] rt;
   } r_fmt_t;

   // Immediate format: ADDI, LOAD, STORE
   typedef struct packed {
      opcode_e          opcode;
      logic [REG_W-1:0] rd;
      logic [REG_W-1:0] rs;
      logic [IMM_W-1:0] imm4;
   } i_fmt_t;

   // Branch format, offset counted in words
   typedef struct packed {
      opcode_e          opcode;
      logic [OFS_W-1:0] offset;
   } b_fmt_t;

   // One word, three views
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      b_fmt_t b;
   } instr_u;

endpackage

`default_nettype wire

/* fetch/fetch_unit.sv */
// Fetch stage: program counter, branch wait flag and bubble insertion
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
   import isa_pkg::*;
   import fetch_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              load_stall,
   input  logic              branch_resolved,
   input  logic              branch_taken,
   input  logic [WORD_W-1:0] branch_target,
   input  logic [WORD_W-1:0] rom_word,
   output logic [WORD_W-1:0] pc,
   output logic              if_valid,
   output logic [WORD_W-1:0] if_pc,
   output logic [WORD_W-1:0] if_instr,
   output logic              fetch_wait
);

   logic [WORD_W-1:0] pc_q;
   logic [WORD_W-1:0] pc_next;
   logic              wait_q;
   logic              wait_next;
   logic              is_branch;

   // No valid fetch while a branch is outstanding
   assign if_valid = !wait_q;
   assign if_pc    = pc_q;
   // Bubble word while waiting
   assign if_instr = wait_q ? NOP_WORD : rom_word;

   // Opcode peek only, full decode happens downstream
   assign is_branch = if_valid && (opcode_e'(rom_word[WORD_W-1:WORD_W-OPC_W]) == OP_BR);

   // Next PC select
   always_comb begin
      pc_next   = pc_q;
      wait_next = wait_q;
      if (branch_resolved) begin
         // Redirect or fall through, wait ends on this edge
         if (branch_taken) begin
            pc_next = branch_target;
         end
         wait_next = 1'b0;
      end else if (!wait_q && !load_stall) begin
         // Normal advance
         pc_next = pc_q + PC_STEP;
         // BR leaving fetch starts the wait
         wait_next = is_branch;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q   <= RESET_PC;
         wait_q <= 1'b0;
      end else begin
         pc_q   <= pc_next;
         wait_q <= wait_next;
      end
   end

   assign pc         = pc_q;
   assign fetch_wait = wait_q;

   // Halfword alignment holds through every redirect
   a_pc_even : assert property (@(posedge clk) disable iff (rst)
      !pc_q[0]);

   // Execute stage resolves only what fetch is waiting on
   a_resolve_in_wait : assert property (@(posedge clk) disable iff (rst)
      branch_resolved |-> wait_q);

   // Taken target must be aligned
   a_target_even : assert property (@(posedge clk) disable iff (rst)
      (branch_resolved && branch_taken) |-> !branch_target[0]);

   // Valid fetches stay inside the ROM image
   a_pc_in_rom : assert property (@(posedge clk) disable iff (rst)
      if_valid |-> (pc_q[WORD_W-1:1] < ROM_WORDS));

endmodule

`default_nettype wire

/* fetch/instr_rom.sv */
// Instruction ROM loaded from the program image, combinational read
`timescale 1ns/1ps
`default_nettype none

module instr_rom
   import isa_pkg::*;
   import fetch_pkg::*;
(
   input  logic [WORD_W-1:0] pc,
   output logic [WORD_W-1:0] rom_word
);

   // Program storage
   logic [WORD_W-1:0] mem [ROM_WORDS];

   // Word address, byte bit dropped
   logic [WORD_W-2:0] word_addr;
   logic              in_range;

   // Image loaded once at time zero
   initial begin
      $readmemh(ROM_FILE, mem);
   end

   assign word_addr = pc[WORD_W-1:1];
   assign in_range  = (word_addr < ROM_WORDS);

   // Same cycle read
   always_comb begin
      if (in_range) begin
         rom_word = mem[word_addr[ROM_AW-1:0]];
      end else begin
         // Past the end reads as NOP
         rom_word = NOP_WORD;
      end
   end

endmodule

`default_nettype wire

/* files.f */
common/isa_pkg.sv
common/fetch_pkg.sv
fetch/instr_rom.sv
fetch/fetch_unit.sv
hdl/instr_decode.sv
hdl/load_use_detect.sv
hdl/cpu_front_end.sv
verif/tb_cpu_front_end.sv

/* hdl/cpu_front_end.sv */
// Front end top: fetch, instruction ROM, decode and load-use detection
`timescale 1ns/1ps
`default_nettype none

module cpu_front_end
   import isa_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              branch_resolved,
   input  logic              branch_taken,
   input  logic [WORD_W-1:0] branch_target,
   output logic [WORD_W-1:0] pc,
   output logic              fetch_wait,
   output logic              load_stall,
   output logic              id_valid,
   output logic [WORD_W-1:0] id_pc,
   output opcode_e           id_opcode,
   output logic [REG_W-1:0]  id_rd,
   output logic [REG_W-1:0]  id_rs,
   output logic [REG_W-1:0]  id_rt,
   output logic [WORD_W-1:0] id_imm
);

   // Fetch to ROM and decode
   logic [WORD_W-1:0] rom_word;
   logic              if_valid;
   logic [WORD_W-1:0] if_pc;
   logic [WORD_W-1:0] if_instr;

   // PC, wait state and bubbles
   fetch_unit u_fetch (
      .clk             (clk),
      .rst             (rst),
      .load_stall      (load_stall),
      .branch_resolved (branch_resolved),
      .branch_taken    (branch_taken),
      .branch_target   (branch_target),
      .rom_word        (rom_word),
      .pc              (pc),
      .if_valid        (if_valid),
      .if_pc           (if_pc),
      .if_instr        (if_instr),
      .fetch_wait      (fetch_wait)
   );

   // Program memory, read in the fetch cycle
   instr_rom u_rom (
      .pc       (pc),
      .rom_word (rom_word)
   );

   // Decode register and fields
   instr_decode u_decode (
      .clk        (clk),
      .rst        (rst),
      .load_stall (load_stall),
      .if_valid   (if_valid),
      .if_pc      (if_pc),
      .if_instr   (if_instr),
      .id_valid   (id_valid),
      .id_pc      (id_pc),
      .id_opcode  (id_opcode),
      .id_rd      (id_rd),
      .id_rs      (id_rs),
      .id_rt      (id_rt),
      .id_imm     (id_imm)
   );

   // Hazard against the load in decode
   load_use_detect u_hazard (
      .if_valid   (if_valid),
      .if_instr   (if_instr),
      .id_valid   (id_valid),
      .id_opcode  (id_opcode),
      .id_rd      (id_rd),
      .load_stall (load_stall)
   );

endmodule

`default_nettype wire

/* hdl/instr_decode.sv */
// Decode stage with pipeline register, bubble load and field split by format
`timescale 1ns/1ps
`default_nettype none

module instr_decode
   import isa_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              load_stall,
   input  logic              if_valid,
   input  logic [WORD_W-1:0] if_pc,
   input  logic [WORD_W-1:0] if_instr,
   output logic              id_valid,
   output logic [WORD_W-1:0] id_pc,
   output opcode_e           id_opcode,
   output logic [REG_W-1:0]  id_rd,
   output logic [REG_W-1:0]  id_rs,
   output logic [REG_W-1:0]  id_rt,
   output logic [WORD_W-1:0] id_imm
);

   logic              valid_q;
   logic [WORD_W-1:0] pc_q;
   instr_u            word_q;

   // Valid flag and word with a NOP bubble on a stall
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= 1'b0;
         word_q  <= NOP_WORD;
      end else if (load_stall) begin
         valid_q <= 1'b0;
         word_q  <= NOP_WORD;
      end else begin
         valid_q <= if_valid;
         // Fetch already sends NOP for its own bubbles
         word_q  <= if_instr;
      end
   end

   // Address travels along with the word
   always_ff @(posedge clk) begin
      pc_q <= if_pc;
   end

   assign id_valid = valid_q;
   assign id_pc    = pc_q;

   // Field split
   always_comb begin
      id_opcode = word_q.r.opcode;
      // rd and rs sit in the same bits for R and I
      id_rd     = word_q.r.rd;
      id_rs     = word_q.r.rs;
      id_rt     = '0;
      id_imm    = '0;
      case (word_q.r.opcode)
         OP_ADD, OP_SUB, OP_AND: begin
            id_rt = word_q.r.rt;
         end
         OP_ADDI, OP_LOAD, OP_STORE: begin
            // Sign extended 4 bit immediate
            id_imm = {{(WORD_W-IMM_W){word_q.i.imm4[IMM_W-1]}}, word_q.i.imm4};
         end
         OP_BR: begin
            // Word offset to byte offset
            id_imm = {{(WORD_W-OFS_W-1){word_q.b.offset[OFS_W-1]}}, word_q.b.offset, 1'b0};
         end
         default: begin
            // NOP and unused codes carry no fields
            id_rt  = '0;
         end
      endcase
   end

   // Decode comes out of reset empty
   a_empty_after_reset : assert property (@(posedge clk)
      rst |=> !valid_q);

   // Bubbles from fetch or from a stall must decode as NOP
   a_bubble_is_nop : assert property (@(posedge clk) disable iff (rst)
      !valid_q |-> (word_q.r.opcode == OP_NOP));

endmodule

`default_nettype wire

/* hdl/load_use_detect.sv */
// Load-use hazard check between the fetched word and a load in decode
`timescale 1ns/1ps
`default_nettype none

module load_use_detect
   import isa_pkg::*;
(
   input  logic              if_valid,
   input  logic [WORD_W-1:0] if_instr,
   input  logic              id_valid,
   input  opcode_e           id_opcode,
   input  logic [REG_W-1:0]  id_rd,
   output logic              load_stall
);

   instr_u f_word;
   logic   uses_rs;
   logic   uses_rt;
   logic   uses_rd;
   logic   src_hit;
   logic   id_is_load;

   assign f_word = if_instr;

   // Source registers per opcode
   always_comb begin
      uses_rs = 1'b0;
      uses_rt = 1'b0;
      uses_rd = 1'b0;
      case (f_word.r.opcode)
         OP_ADD, OP_SUB, OP_AND: begin
            uses_rs = 1'b1;
            uses_rt = 1'b1;
         end
         OP_ADDI, OP_LOAD: begin
            uses_rs = 1'b1;
         end
         OP_STORE: begin
            // Base register plus the stored data register
            uses_rs = 1'b1;
            uses_rd = 1'b1;
         end
         default: begin
            // NOP and BR read nothing
            uses_rs = 1'b0;
         end
      endcase
   end

   // Any read source matching the load destination
   assign src_hit = (uses_rs && (f_word.i.rs == id_rd)) ||
                    (uses_rt && (f_word.r.rt == id_rd)) ||
                    (uses_rd && (f_word.i.rd == id_rd));

   assign id_is_load = id_valid && (id_opcode == OP_LOAD);

   // Stall only against a real fetch
   assign load_stall = id_is_load && if_valid && src_hit;

endmodule

`default_nettype wire

/* verif/program.hex */
// One instruction word per line: opcode, rd, rs, rt or imm4 nibbles (BR: opcode, 12-bit offset)
4105  // 00 ADDI r1, r0, 5
420D  // 02 ADDI r2, r0, -3
1312  // 04 ADD r3, r1, r2
2431  // 06 SUB r4, r3, r1
5512  // 08 LOAD r5, r1, 2
1652  // 0a ADD r6, r5, r2, stall on rs
572F  // 0c LOAD r7, r2, -1
0000  // 0e NOP, no stall
5810  // 10 LOAD r8, r1, 0
3923  // 12 AND r9, r2, r3, no match
5A18  // 14 LOAD r10, r1, -8
6A21  // 16 STORE r10, r2, 1, stall on rd
5B34  // 18 LOAD r11, r3, 4
1C1B  // 1a ADD r12, r1, r11, stall on rt
7003  // 1c BR +3 words to 22
4111  // 1e ADDI r1, r1, 1
2221  // 20 SUB r2, r2, r1
5D07  // 22 LOAD r13, r0, 7
4EDE  // 24 ADDI r14, r13, -2, stall
5F43  // 26 LOAD r15, r4, 3
51F0  // 28 LOAD r1, r15, 0, stall
7002  // 2a BR +2 words to 2e
1211  // 2c ADD r2, r1, r1
630C  // 2e STORE r3, r0, -4
4437  // 30 ADDI r4, r3, 7
7002  // 32 BR +2 words to 36
3543  // 34 AND r5, r4, r3
565E  // 36 LOAD r6, r5, -2
7002  // 38 BR +2 words to 3c, reads nothing
0000  // 3a NOP
2766  // 3c SUB r7, r6, r6
7FE1  // 3e BR -31 words back to 00

/* verif/tb_cpu_front_end.sv */
// Front end testbench with clock, reset, execute stand-in, reference model and assertions
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_front_end
   import isa_pkg::*;
   import fetch_pkg::*;
();

   // DUT ports
   logic              clk;
   logic              rst;
   logic              branch_resolved;
   logic              branch_taken;
   logic [WORD_W-1:0] branch_target;
   logic [WORD_W-1:0] pc;
   logic              fetch_wait;
   logic              load_stall;
   logic              id_valid;
   logic [WORD_W-1:0] id_pc;
   opcode_e           id_opcode;
   logic [REG_W-1:0]  id_rd;
   logic [REG_W-1:0]  id_rs;
   logic [REG_W-1:0]  id_rt;
   logic [WORD_W-1:0] id_imm;

   // Reference model state and bookkeeping
   logic [WORD_W-1:0] prog [ROM_WORDS];
   logic [WORD_W-1:0] m_pc;
   logic              m_wait;
   logic              m_id_valid;
   logic [WORD_W-1:0] m_id_pc;
   logic [WORD_W-1:0] m_id_word;
   logic [WORD_W-1:0] m_if_word;
   logic              m_stall;
   logic [WORD_W-1:0] redirect_pc  = '0;
   logic [31:0]       lfsr_state   = 32'hb502_cd95;
   int                err_cnt      = 0;
   int                stall_cnt    = 0;
   int                resolve_cnt  = 0;
   int                tests_passed = 0;
   int                tests_failed = 0;

   cpu_front_end dut0 (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // Source registers per format
   function automatic logic reads_reg(input logic [15:0] w, input logic [3:0] r);
      case (opcode_e'(w[15:12]))
         OP_ADD, OP_SUB, OP_AND: return (w[7:4] == r) || (w[3:0] == r);
         OP_ADDI, OP_LOAD: return w[7:4] == r;
         OP_STORE: return (w[7:4] == r) || (w[11:8] == r);
         default: return 1'b0;
      endcase
   endfunction

   // Opcode, rd, rs, rt and immediate as decode should show them
   function automatic logic [31:0] expected_fields(input logic [15:0] w);
      logic [3:0]  rt;
      logic [15:0] imm;
      rt  = 4'h0;
      imm = 16'h0000;
      case (opcode_e'(w[15:12]))
         OP_ADD, OP_SUB, OP_AND: rt = w[3:0];
         OP_ADDI, OP_LOAD, OP_STORE: imm = 16'($signed(w[3:0]));
         // Word offset becomes a byte offset
         OP_BR: imm = 16'($signed(w[11:0])) << 1;
         default: rt = 4'h0;
      endcase
      return {w[15:4], rt, imm};
   endfunction

   // Galois LFSR stepped once per bit drawn
   function automatic logic next_random_bit();
      logic b;
      b          = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (b ? 32'hB4BC_D35C : 32'h0);
      return b;
   endfunction

   task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
      err_cnt++;
      $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
   endtask

   // Model fetch word is a bubble while waiting and NOP past the ROM end
   assign m_if_word = (m_wait || m_pc[15:1] >= ROM_WORDS) ? '0 : prog[m_pc[ROM_AW:1]];
   assign m_stall   = m_id_valid && (m_id_word[15:12] == OP_LOAD) && !m_wait
                      && reads_reg(m_if_word, m_id_word[11:8]);

   always @(posedge clk) begin
      if (rst) begin
         m_pc       <= RESET_PC;
         m_wait     <= 1'b0;
         m_id_valid <= 1'b0;
      end else begin
         if (branch_resolved) begin
            m_pc   <= branch_taken ? branch_target : m_pc;
            m_wait <= 1'b0;
         end else if (!m_wait && !m_stall) begin
            m_pc   <= m_pc + PC_STEP;
            m_wait <= (m_if_word[15:12] == OP_BR);
         end
         // Stall puts a bubble into decode
         m_id_valid <= !m_wait && !m_stall;
         m_id_word  <= m_stall ? '0 : m_if_word;
         m_id_pc    <= m_pc;
         stall_cnt  += int'(load_stall);
         resolve_cnt += int'(branch_resolved);
      end
   end

   // Cycle by cycle compare against the model
   a_pc : assert property (@(posedge clk) disable iff (rst) pc == m_pc)
      else mismatch("pc", $sampled(m_pc), $sampled(pc));
   a_wait : assert property (@(posedge clk) disable iff (rst) fetch_wait == m_wait)
      else mismatch("fetch_wait", $sampled(m_wait), $sampled(fetch_wait));
   a_stall : assert property (@(posedge clk) disable iff (rst) load_stall == m_stall)
      else mismatch("load_stall", $sampled(m_stall), $sampled(load_stall));
   a_id_valid : assert property (@(posedge clk) disable iff (rst) id_valid == m_id_valid)
      else mismatch("id_valid", $sampled(m_id_valid), $sampled(id_valid));
   a_id_pc : assert property (@(posedge clk) disable iff (rst) id_valid |-> id_pc == m_id_pc)
      else mismatch("id_pc", $sampled(m_id_pc), $sampled(id_pc));
   a_fields : assert property (@(posedge clk) disable iff (rst)
      id_valid |-> {id_opcode, id_rd, id_rs, id_rt, id_imm} == expected_fields(m_id_word))
      else mismatch("id fields", expected_fields($sampled(m_id_word)),
                    $sampled({id_opcode, id_rd, id_rs, id_rt, id_imm}));
   // Resolve drops the wait and decode then shows the redirect address
   a_redirect : assert property (@(posedge clk) disable iff (rst)
      branch_resolved |=> !fetch_wait ##1 (id_valid && id_pc == redirect_pc))
      else mismatch("id_pc after resolve", $sampled(redirect_pc), $sampled(id_pc));

   // Execute stand-in resolving each branch after 0 to 3 extra cycles
   initial begin : execute_stage
      logic [WORD_W-1:0] br_pc;
      logic [WORD_W-1:0] target;
      int                delay;
      logic              taken;
      forever begin
         @(negedge clk);
         if (!rst && id_valid && id_opcode == OP_BR) begin
            br_pc  = m_id_pc;
            target = id_pc + id_imm;
            delay  = next_random_bit();
            delay  = delay * 2 + next_random_bit();
            // Last word always branches home so fetch stays in the ROM
            taken  = next_random_bit() || (br_pc == 16'(2 * (ROM_WORDS - 1)));
            repeat (delay) @(negedge clk);
            branch_taken    = taken;
            branch_target   = target;
            redirect_pc     = taken ? target : br_pc + PC_STEP;
            branch_resolved = 1'b1;
            @(negedge clk);
            branch_resolved = 1'b0;
         end
      end
   end

   // Waits for a count of stalls or resolves, sampled at the falling edge
   task automatic wait_events(input logic resolves, input int target, input int limit,
                              output logic ok);
      ok = 1'b0;
      for (int n = 0; n < limit && !ok; n++) begin
         @(negedge clk);
         ok = resolves ? (resolve_cnt >= target) : (stall_cnt >= target);
      end
      if (!ok) begin
         $display("Timeout: %0d %s not seen within %0d cycles", target,
                  resolves ? "branch resolves" : "load stalls", limit);
      end
   endtask

   task automatic end_test(input string name, input int errs_before, input logic ok);
      if (ok && err_cnt == errs_before) begin
         tests_passed++;
         $display("test %s: passed", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d check errors", name, err_cnt - errs_before);
      end
   endtask

   initial begin : main
      int   errs_before;
      logic ok;
      rst             = 1'b1;
      branch_resolved = 1'b0;
      branch_taken    = 1'b0;
      branch_target   = '0;
      $readmemh(ROM_FILE, prog);
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      errs_before = err_cnt;
      wait_events(1'b0, 1, 40, ok);
      end_test("reset and sequential fetch", errs_before, ok);
      errs_before = err_cnt;
      wait_events(1'b0, 5, 200, ok);
      end_test("load-use stall", errs_before, ok);
      errs_before = err_cnt;
      wait_events(1'b1, 16, 800, ok);
      end_test("branch wait and redirect", errs_before, ok);
      // Last redirect reaches decode
      repeat (3) @(negedge clk);
      $display("tests passed %0d, tests failed %0d, check errors %0d",
               tests_passed, tests_failed, err_cnt);
      if (tests_failed == 0 && err_cnt == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
